//--- cmd_pkg.sv
package cmd_pkg;

    localparam int CMD_ADDR_BITS = 14; // slave register address width

    // one register write as seen by the slaves
    typedef struct packed {
        logic [CMD_ADDR_BITS-1:0] addr; // register address
        logic [31:0]              data; // register data
    } cmd_word_t;                       // 46 bits in all

    typedef enum logic [1:0] {
        SRC_NONE = 2'd0, // nothing issued this cycle
        SRC_SEQ  = 2'd1, // frame sequencer holding register
        SRC_HOST = 2'd2  // host write fifo
    } cmd_src_e;

    typedef enum logic [1:0] {
        SER_IDLE   = 2'd0, // no byte on byte_ad
        SER_SINGLE = 2'd1, // strobe cycle of a one-byte command
        SER_STREAM = 2'd2  // inside a multi-byte stream
    } ser_state_e;

    typedef logic [2:0] cmd_len_t; // bytes per command, 1..6

    // index is the 4-bit length field taken from the command address
    localparam cmd_len_t CMD_LEN_TABLE [16] = '{
        3'd1, // 0: address low only
        3'd2, // 1: address low and high
        3'd3, // 2: address plus data byte 0
        3'd4, // 3: up to data byte 1
        3'd5, // 4: up to data byte 2
        3'd6, // 5: full word
        3'd6, // 6
        3'd6, // 7
        3'd6, // 8
        3'd6, // 9
        3'd6, // 10
        3'd6, // 11
        3'd6, // 12
        3'd6, // 13
        3'd6, // 14
        3'd6  // 15
    };

endpackage

//--- cmd_host_fifo.sv
`timescale 1ns/1ps

module cmd_host_fifo #(
    parameter int unsigned                        FIFO_DEPTH = 4,        // power of two
    parameter logic [cmd_pkg::CMD_ADDR_BITS-1:0] CTRL_BASE  = 14'h2000, // window base
    parameter logic [cmd_pkg::CMD_ADDR_BITS-1:0] CTRL_MASK  = 14'h3c00  // bits compared
) (
    input  logic               rst,         // clock
    input  logic               mclk,        // async reset, active high
    input  logic               host_wr,     // single-cycle write strobe
    input  cmd_pkg::cmd_word_t host_cmd,    // address/data with host_wr
    input  logic               fifo_pop,    // controller takes the head entry
    output cmd_pkg::cmd_word_t fifo_cmd,    // head entry
    output logic               fifo_nempty, // at least one entry queued
    output logic               busy         // host should hold off
);

    import cmd_pkg::*;

    localparam int unsigned PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_BITS = PTR_BITS + 1;   // count has to reach FIFO_DEPTH

    cmd_word_t            mem [FIFO_DEPTH]; // entry storage
    logic [PTR_BITS-1:0]  wr_ptr;           // next slot to write
    logic [PTR_BITS-1:0]  rd_ptr;           // current head slot
    logic [CNT_BITS-1:0]  count;            // entries held
    logic                 in_window;        // address hits the control window
    logic                 full;
    logic                 push;
    logic                 pop;
    logic                 busy_r;

    // only the masked address bits are compared against the base
    assign in_window = ((host_cmd.addr ^ CTRL_BASE) & CTRL_MASK) == '0;

    assign full = (count == CNT_BITS'(FIFO_DEPTH));
    assign push = host_wr && in_window && !full; // a write into a full fifo is lost
    assign pop  = fifo_pop && fifo_nempty;       // ignore a pop of an empty fifo

    // storage has no reset, entries are only read below count
    always_ff @(posedge rst) begin
        if (push) begin
            mem[wr_ptr] <= host_cmd;
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_BITS'(1); // wraps at the power-of-two depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_BITS'(1);
            end
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + CNT_BITS'(1);
                2'b01:   count <= count - CNT_BITS'(1);
                default: count <= count; // idle, or push and pop together
            endcase
        end
    end

    // busy follows the occupancy one cycle late
    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            busy_r <= 1'b0;
        end else begin
            busy_r <= (count >= CNT_BITS'(FIFO_DEPTH / 2));
        end
    end

    assign fifo_cmd    = mem[rd_ptr];
    assign fifo_nempty = (count != '0);
    assign busy        = busy_r;

endmodule

//--- cmd_arb_ctrl.sv
`timescale 1ns/1ps

module cmd_arb_ctrl (
    input  logic               rst,         // clock
    input  logic               mclk,        // async reset, active high
    input  logic               seq_wr,      // sequencer request, held until seq_ack
    input  cmd_pkg::cmd_word_t seq_cmd,     // sequencer address/data
    output logic               seq_ack,     // sequencer command taken at this edge
    input  cmd_pkg::cmd_word_t fifo_cmd,    // head of the host fifo
    input  logic               fifo_nempty, // host command waiting
    output logic               fifo_pop,    // host head consumed
    input  logic               can_start,   // serializer ready for a load
    output logic               start,       // load strobe to the serializer
    output cmd_pkg::cmd_word_t start_cmd,   // command to load
    output cmd_pkg::cmd_src_e  start_src    // its source
);

    import cmd_pkg::*;

    logic      hold_full; // holding register has a pending sequencer command
    cmd_word_t hold_cmd;  // the pending sequencer command
    cmd_src_e  sel;       // source chosen this cycle

    // sequencer beats host, nothing is chosen while the serializer is busy
    always_comb begin
        sel = SRC_NONE;
        if (can_start) begin
            if (hold_full) begin
                sel = SRC_SEQ;
            end else if (fifo_nempty) begin
                sel = SRC_HOST;
            end
        end
    end

    always_comb begin
        case (sel)
            SRC_SEQ: start_cmd = hold_cmd;
            default: start_cmd = fifo_cmd; // don't care with SRC_NONE
        endcase
    end

    assign start     = (sel != SRC_NONE);
    assign start_src = sel;
    assign fifo_pop  = (sel == SRC_HOST);

    // holding register frees up in the same cycle it is started
    assign seq_ack = seq_wr && (!hold_full || (sel == SRC_SEQ));

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            hold_full <= 1'b0;
        end else begin
            hold_full <= seq_ack || (hold_full && (sel != SRC_SEQ));
        end
    end

    always_ff @(posedge rst) begin
        if (seq_ack) begin
            hold_cmd <= seq_cmd; // eligible from the next cycle
        end
    end

endmodule

//--- cmd_serializer.sv
`timescale 1ns/1ps

module cmd_serializer #(
    parameter int unsigned LEN_LSB = 6 // lowest address bit of the length index
) (
    input  logic               rst,       // clock
    input  logic               mclk,      // async reset, active high
    input  logic               start,     // load a new command this cycle
    input  cmd_pkg::cmd_word_t start_cmd, // command to load
    input  cmd_pkg::cmd_src_e  start_src, // where start_cmd came from
    output logic               can_start, // a load is allowed in this cycle
    output logic               ad_stb,    // first byte and parallel word valid
    output cmd_pkg::cmd_word_t par_cmd,   // parallel address/data
    output logic [7:0]         byte_ad,   // AL, AH, D0..D3
    output cmd_pkg::cmd_src_e  last_src   // source of the current command
);

    import cmd_pkg::*;

    localparam int unsigned PAD_BITS = 16 - CMD_ADDR_BITS; // address padded to two bytes

    logic [47:0] shift_r;    // {data, padded address}, low byte on the bus
    logic        ad_stb_r;
    ser_state_e  state_r;    // current phase
    cmd_len_t    rem_r;      // bytes still to follow the current one
    cmd_len_t    len_in;     // length of the command being loaded
    cmd_src_e    last_src_r;

    // length index sits inside the address
    assign len_in = CMD_LEN_TABLE[start_cmd.addr[LEN_LSB +: 4]];

    // payload shifts down one byte each cycle, zeros come in from the top
    always_ff @(posedge rst) begin
        if (start) begin
            shift_r <= {start_cmd.data, {PAD_BITS{1'b0}}, start_cmd.addr};
        end else begin
            shift_r <= {8'h00, shift_r[47:8]};
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            ad_stb_r <= 1'b0;
        end else begin
            ad_stb_r <= start; // strobe one cycle after the load request
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            state_r <= SER_IDLE;
            rem_r   <= '0;
        end else if (start) begin
            rem_r <= len_in - cmd_len_t'(1); // strobe cycle carries the first byte
            if (len_in == cmd_len_t'(1)) begin
                state_r <= SER_SINGLE;
            end else begin
                state_r <= SER_STREAM;
            end
        end else begin
            case (state_r)
                SER_SINGLE: state_r <= SER_IDLE;
                SER_STREAM: begin
                    if (rem_r == '0) begin
                        state_r <= SER_IDLE; // last byte just went out
                    end else begin
                        rem_r <= rem_r - cmd_len_t'(1);
                    end
                end
                default:    state_r <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            last_src_r <= SRC_NONE;
        end else if (start) begin
            last_src_r <= start_src;
        end
    end

    // idle, strobe of a one-byte command, or last byte of a stream
    assign can_start = (state_r == SER_IDLE) || (state_r == SER_SINGLE) ||
                       ((state_r == SER_STREAM) && (rem_r == '0));

    assign ad_stb       = ad_stb_r;
    assign par_cmd.addr = shift_r[CMD_ADDR_BITS-1:0]; // valid with ad_stb only
    assign par_cmd.data = shift_r[47:16];
    assign byte_ad      = (state_r != SER_IDLE) ? shift_r[7:0] : 8'h00; // zero past the length
    assign last_src     = last_src_r;

endmodule

//--- cmd_mux_top.sv
`timescale 1ns/1ps

module cmd_mux_top #(
    parameter int unsigned                        FIFO_DEPTH = 4,        // host fifo entries
    parameter logic [cmd_pkg::CMD_ADDR_BITS-1:0] CTRL_BASE  = 14'h2000, // control window base
    parameter logic [cmd_pkg::CMD_ADDR_BITS-1:0] CTRL_MASK  = 14'h3c00, // control window mask
    parameter int unsigned                        LEN_LSB    = 6         // length index position
) (
    input  logic               rst,      // clock
    input  logic               mclk,     // async reset, active high
    input  logic               host_wr,  // host write strobe
    input  cmd_pkg::cmd_word_t host_cmd,
    output logic               busy,     // host should stop writing
    input  logic               seq_wr,   // sequencer request
    input  cmd_pkg::cmd_word_t seq_cmd,
    output logic               seq_ack,  // combinational accept
    output logic               ad_stb,   // slave strobe
    output cmd_pkg::cmd_word_t par_cmd,  // parallel word to slaves
    output logic [7:0]         byte_ad,  // serial bytes to slaves
    output cmd_pkg::cmd_src_e  cmd_src   // source of the command on the bus
);

    import cmd_pkg::*;

    cmd_word_t fifo_cmd;
    logic      fifo_nempty;
    logic      fifo_pop;
    logic      can_start;
    logic      start;
    cmd_word_t start_cmd;
    cmd_src_e  start_src;

    cmd_host_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CTRL_BASE  (CTRL_BASE),
        .CTRL_MASK  (CTRL_MASK)
    ) u_fifo (
        .rst         (rst),
        .mclk        (mclk),
        .host_wr     (host_wr),
        .host_cmd    (host_cmd),
        .fifo_pop    (fifo_pop),
        .fifo_cmd    (fifo_cmd),
        .fifo_nempty (fifo_nempty),
        .busy        (busy)
    );

    cmd_arb_ctrl u_ctrl (
        .rst         (rst),
        .mclk        (mclk),
        .seq_wr      (seq_wr),
        .seq_cmd     (seq_cmd),
        .seq_ack     (seq_ack),
        .fifo_cmd    (fifo_cmd),
        .fifo_nempty (fifo_nempty),
        .fifo_pop    (fifo_pop),
        .can_start   (can_start),
        .start       (start),
        .start_cmd   (start_cmd),
        .start_src   (start_src)
    );

    cmd_serializer #(
        .LEN_LSB (LEN_LSB)
    ) u_ser (
        .rst       (rst),
        .mclk      (mclk),
        .start     (start),
        .start_cmd (start_cmd),
        .start_src (start_src),
        .can_start (can_start),
        .ad_stb    (ad_stb),
        .par_cmd   (par_cmd),
        .byte_ad   (byte_ad),
        .last_src  (cmd_src)
    );

endmodule

//--- cmd_mux_sva.sv
`timescale 1ns/1ps

module cmd_mux_sva #(
    parameter int unsigned LEN_LSB = 6
) (
    input logic                 rst,       // clock
    input logic                 mclk,      // reset
    input logic                 can_start,
    input logic                 ad_stb,
    input cmd_pkg::cmd_word_t   par_cmd,
    input cmd_pkg::ser_state_e  state_r
);

    import cmd_pkg::*;

    int       fail_cnt = 0; // read by the testbench summary
    cmd_len_t cur_len;      // length of the command under ad_stb
    int       gap_left;     // cycles in which no new strobe may come

    assign cur_len = CMD_LEN_TABLE[par_cmd.addr[LEN_LSB +: 4]];

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            gap_left <= 0;
        end else if (ad_stb) begin
            gap_left <= int'(cur_len) - 1; // a one-byte command leaves no gap
        end else if (gap_left != 0) begin
            gap_left <= gap_left - 1;
        end
    end

    a_no_overlap: assert property (@(posedge rst) disable iff (mclk) gap_left != 0 |-> !ad_stb)
        else begin
            fail_cnt++;
            $error("ad_stb came before the previous stream ended");
        end

    // phase must drop back to idle once the table length has run out
    a_stream_end: assert property (@(posedge rst) disable iff (mclk)
                                   !ad_stb && gap_left == 0 |-> state_r == SER_IDLE)
        else begin
            fail_cnt++;
            $error("serializer still active after the command length ran out");
        end

    a_stream_hold: assert property (@(posedge rst) disable iff (mclk)
                                    ad_stb && cur_len > 3'd1 |-> !can_start)
        else begin
            fail_cnt++;
            $error("can_start high in the strobe cycle of a long command");
        end

endmodule

bind cmd_serializer cmd_mux_sva #(.LEN_LSB(LEN_LSB)) u_sva (
    .rst       (rst),
    .mclk      (mclk),
    .can_start (can_start),
    .ad_stb    (ad_stb),
    .par_cmd   (par_cmd),
    .state_r   (state_r)
);

//--- cmd_mux_tb.sv
`timescale 1ns/1ps

module cmd_mux_tb;

    import cmd_pkg::*;

    localparam int                       FIFO_DEPTH = 4;
    localparam logic [CMD_ADDR_BITS-1:0] CTRL_BASE  = 14'h2000;
    localparam logic [CMD_ADDR_BITS-1:0] CTRL_MASK  = 14'h3c00;
    localparam int                       LEN_LSB    = 6;
    localparam int                       CLK_PERIOD = 100;  // ns
    localparam int                       N_HOST     = 240;  // host writes, some miss the window
    localparam int                       N_SEQ      = 60;   // sequencer commands
    localparam int                       N_CMDS     = N_HOST + N_SEQ;
    localparam int unsigned              SEED       = 32'h91e1;

    logic       rst;      // clock
    logic       mclk;     // reset
    logic       host_wr;
    cmd_word_t  host_cmd;
    logic       busy;
    logic       seq_wr;
    cmd_word_t  seq_cmd;
    logic       seq_ack;
    logic       ad_stb;
    cmd_word_t  par_cmd;
    logic [7:0] byte_ad;
    cmd_src_e   cmd_src;

    cmd_word_t  host_q [$];   // expected fifo contents, head first
    int         m_cnt;        // model fifo occupancy
    logic       m_hold_full;  // model sequencer holding register
    cmd_word_t  m_hold_cmd;
    cmd_word_t  m_cur_cmd;    // command the slave side should carry
    cmd_src_e   m_cur_src;
    int         m_left;       // byte cycles left, current one included
    int         m_pos;        // index of the byte on the bus
    logic       m_stb;        // expected ad_stb
    logic       m_busy;       // expected busy
    cmd_src_e   m_sel;        // source the model starts this cycle
    logic       m_ack;
    logic       m_push;
    logic       m_idle;
    logic [7:0] m_byte;       // expected byte_ad
    logic       idle_trig;    // request into an idle subsystem

    int err_order   = 0;
    int err_byte    = 0;
    int err_flag    = 0;
    int err_timing  = 0;
    int err_timeout = 0;

    cmd_mux_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CTRL_BASE  (CTRL_BASE),
        .CTRL_MASK  (CTRL_MASK),
        .LEN_LSB    (LEN_LSB)
    ) u_dut (
        .rst      (rst),
        .mclk     (mclk),
        .host_wr  (host_wr),
        .host_cmd (host_cmd),
        .busy     (busy),
        .seq_wr   (seq_wr),
        .seq_cmd  (seq_cmd),
        .seq_ack  (seq_ack),
        .ad_stb   (ad_stb),
        .par_cmd  (par_cmd),
        .byte_ad  (byte_ad),
        .cmd_src  (cmd_src)
    );

    always #(CLK_PERIOD / 2) rst = ~rst;

    function automatic bit addr_in_window(logic [CMD_ADDR_BITS-1:0] a);
        return (a & CTRL_MASK) == (CTRL_BASE & CTRL_MASK);
    endfunction

    function automatic int cmd_length(cmd_word_t c);
        return int'(CMD_LEN_TABLE[c.addr[LEN_LSB +: 4]]);
    endfunction

    // serial order is AL, AH, D0..D3
    function automatic logic [7:0] byte_of(cmd_word_t c, int idx);
        logic [15:0] a16;
        a16 = 16'(c.addr); // address padded with zeros
        case (idx)
            0:       return a16[7:0];
            1:       return a16[15:8];
            2:       return c.data[7:0];
            3:       return c.data[15:8];
            4:       return c.data[23:16];
            default: return c.data[31:24];
        endcase
    endfunction

    function automatic cmd_word_t random_cmd(bit in_win);
        cmd_word_t   c;
        logic [31:0] r;
        r      = $urandom();
        c.addr = r[CMD_ADDR_BITS-1:0];
        c.data = $urandom();
        if (in_win) begin
            c.addr = (c.addr & ~CTRL_MASK) | (CTRL_BASE & CTRL_MASK);
        end
        if ($urandom_range(3) == 0) begin
            c.addr[LEN_LSB +: 4] = 4'd0; // extra one-byte commands
        end
        return c;
    endfunction

    // what the subsystem should do in the current cycle
    always_comb begin
        m_sel = SRC_NONE;
        if (m_left <= 1) begin                 // idle or last byte
            if (m_hold_full) begin
                m_sel = SRC_SEQ;
            end else if (m_cnt != 0) begin
                m_sel = SRC_HOST;
            end
        end
        m_ack     = seq_wr && (!m_hold_full || (m_sel == SRC_SEQ));
        m_push    = host_wr && addr_in_window(host_cmd.addr) && (m_cnt < FIFO_DEPTH);
        m_idle    = (m_left == 0) && !m_hold_full && (m_cnt == 0);
        m_byte    = (m_left != 0) ? byte_of(m_cur_cmd, m_pos) : 8'h00;
        idle_trig = m_idle && (m_push || m_ack);
    end

    always @(posedge rst) begin
        cmd_word_t head;
        if (mclk) begin
            host_q.delete();
            m_cnt       <= 0;
            m_hold_full <= 1'b0;
            m_hold_cmd  <= '0;
            m_cur_cmd   <= '0;
            m_cur_src   <= SRC_NONE;
            m_left      <= 0;
            m_pos       <= 0;
            m_stb       <= 1'b0;
            m_busy      <= 1'b0;
        end else begin
            head = m_cur_cmd;
            if (m_sel == SRC_SEQ) begin
                head = m_hold_cmd;
            end else if (m_sel == SRC_HOST) begin
                head = host_q.pop_front();         // pop before this cycle's push
            end
            m_stb  <= (m_sel != SRC_NONE);         // strobe one cycle after start
            m_busy <= (m_cnt >= FIFO_DEPTH / 2);   // occupancy seen one cycle late
            if (m_sel != SRC_NONE) begin
                m_cur_cmd <= head;
                m_cur_src <= m_sel;
                m_left    <= cmd_length(head);
                m_pos     <= 0;
            end else if (m_left != 0) begin
                m_left <= m_left - 1;
                m_pos  <= m_pos + 1;
            end
            if (m_ack) begin
                m_hold_full <= 1'b1;
                m_hold_cmd  <= seq_cmd;
            end else if (m_sel == SRC_SEQ) begin
                m_hold_full <= 1'b0;
            end
            if (m_push) begin
                host_q.push_back(host_cmd);
            end
            m_cnt <= m_cnt + (m_push ? 1 : 0) - ((m_sel == SRC_HOST) ? 1 : 0);
        end
    end

    a_stb: assert property (@(posedge rst) disable iff (mclk) ad_stb == m_stb)
        else begin
            err_order++;
            $display("[ERROR] %0t ad_stb expected %0b actual %0b",
                     $time, $sampled(m_stb), $sampled(ad_stb));
        end

    a_par: assert property (@(posedge rst) disable iff (mclk) ad_stb |-> par_cmd == m_cur_cmd)
        else begin
            err_order++;
            $display("[ERROR] %0t par_cmd expected %h actual %h",
                     $time, $sampled(m_cur_cmd), $sampled(par_cmd));
        end

    a_src: assert property (@(posedge rst) disable iff (mclk) ad_stb |-> cmd_src == m_cur_src)
        else begin
            err_order++;
            $display("[ERROR] %0t cmd_src expected %0d actual %0d",
                     $time, $sampled(m_cur_src), $sampled(cmd_src));
        end

    a_byte: assert property (@(posedge rst) disable iff (mclk) byte_ad == m_byte)
        else begin
            err_byte++;
            $display("[ERROR] %0t byte_ad expected %h actual %h",
                     $time, $sampled(m_byte), $sampled(byte_ad));
        end

    a_busy: assert property (@(posedge rst) disable iff (mclk) busy == m_busy)
        else begin
            err_flag++;
            $display("[ERROR] %0t busy expected %0b actual %0b",
                     $time, $sampled(m_busy), $sampled(busy));
        end

    a_ack: assert property (@(posedge rst) disable iff (mclk) seq_ack == m_ack)
        else begin
            err_flag++;
            $display("[ERROR] %0t seq_ack expected %0b actual %0b",
                     $time, $sampled(m_ack), $sampled(seq_ack));
        end

    a_ack_no_req: assert property (@(posedge rst) disable iff (mclk) !seq_wr |-> !seq_ack)
        else begin
            err_flag++;
            $display("[ERROR] %0t seq_ack expected 0 actual 1", $time);
        end

    a_idle_latency: assert property (@(posedge rst) disable iff (mclk)
                                     $past(idle_trig, 2) |-> ad_stb)
        else begin
            err_timing++;
            $display("[ERROR] %0t ad_stb expected 1 actual 0", $time);
        end

    // flags are quiet right out of reset
    a_reset_state: assert property (@(posedge rst) $fell(mclk) |-> !ad_stb && !busy && !seq_ack)
        else begin
            err_flag++;
            $display("[ERROR] %0t ad_stb/busy/seq_ack expected 000 actual %0b%0b%0b",
                     $time, $sampled(ad_stb), $sampled(busy), $sampled(seq_ack));
        end

    task automatic print_summary_and_finish();
        int proto;
        int total;
        proto = u_dut.u_ser.u_sva.fail_cnt;
        total = err_order + err_byte + err_flag + err_timing + err_timeout + proto;
        $display("errors: order %0d bytes %0d flags %0d latency %0d timeout %0d protocol %0d",
                 err_order, err_byte, err_flag, err_timing, err_timeout, proto);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        #(CLK_PERIOD * (N_CMDS * 8 + 200));
        $display("timeout: commands still pending when the watchdog limit was reached");
        err_timeout++;
        print_summary_and_finish();
    end

    initial begin
        int cyc;
        bit quiet;
        int host_sent;
        int seq_raised;
        int seq_taken;
        cyc        = 0;
        host_sent  = 0;
        seq_raised = 0;
        seq_taken  = 0;
        void'($urandom(SEED));
        rst      = 1'b0;
        mclk     = 1'b1;
        host_wr  = 1'b0;
        host_cmd = '0;
        seq_wr   = 1'b0;
        seq_cmd  = '0;
        repeat (4) @(posedge rst);
        mclk <= 1'b0;
        while (host_sent < N_HOST || seq_taken < N_SEQ) begin
            @(posedge rst);
            cyc++;
            quiet   = (cyc % 64) >= 48;            // lets the pipe run dry now and then
            host_wr <= 1'b0;
            if (seq_wr && seq_ack) begin           // taken at this edge
                seq_taken++;
                seq_wr <= 1'b0;
            end
            if ((!seq_wr || seq_ack) && !quiet && seq_raised < N_SEQ &&
                $urandom_range(7) == 0) begin
                seq_wr  <= 1'b1;
                seq_cmd <= random_cmd(1'b0);
                seq_raised++;
            end
            if (!quiet && !busy && host_sent < N_HOST && $urandom_range(3) == 0) begin
                host_wr  <= 1'b1;
                host_cmd <= random_cmd($urandom_range(3) != 0); // a quarter miss the window
                host_sent++;
            end
        end
        @(posedge rst);
        host_wr <= 1'b0;
        do begin
            @(posedge rst);
        end while (!m_idle || m_stb);
        repeat (8) @(posedge rst);
        print_summary_and_finish();
    end

endmodule

//--- all.f
cmd_pkg.sv
cmd_host_fifo.sv
cmd_arb_ctrl.sv
cmd_serializer.sv
cmd_mux_top.sv
cmd_mux_sva.sv
cmd_mux_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       ?= cmd_mux_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
